//--- hdl/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

	typedef logic [31:0] instrT;
	typedef logic [6:0] opcodeT;
	typedef logic [2:0] funct3T;
	typedef logic [2:0] aluOpT;
	typedef logic [2:0] muxSelT;
	typedef logic [2:0] memTypeT; // Load or store width code

	// ALU operation codes
	localparam aluOpT AluLoad = 3'd0;
	localparam aluOpT AluSum = 3'd1;
	localparam aluOpT AluSub = 3'd2;
	localparam aluOpT AluAnd = 3'd3;
	localparam aluOpT AluCompare = 3'd7; // Signed compare for blt

	// Second ALU operand
	localparam muxSelT SelBRegB = 3'd0;
	localparam muxSelT SelBFour = 3'd1;
	localparam muxSelT SelBImm = 3'd2;
	localparam muxSelT SelBBranchOff = 3'd3;

	// Source of the memory and register write path
	localparam muxSelT SelMemAluOut = 3'd0;
	localparam muxSelT SelMemData = 3'd1;
	localparam muxSelT SelMemImm = 3'd2;
	localparam muxSelT SelMemShift = 3'd3;

	localparam memTypeT MemNone = 3'd0;
	localparam memTypeT LdDouble = 3'd1;
	localparam memTypeT LdWord = 3'd2;
	localparam memTypeT LdHalf = 3'd3;
	localparam memTypeT LdByte = 3'd4;
	localparam memTypeT LdByteU = 3'd5;
	localparam memTypeT LdHalfU = 3'd6;
	localparam memTypeT LdWordU = 3'd7;
	localparam memTypeT StDouble = 3'd1;
	localparam memTypeT StWord = 3'd2;
	localparam memTypeT StHalf = 3'd3;
	localparam memTypeT StByte = 3'd4;

	// Major opcodes
	localparam opcodeT OpcR = 7'b0110011;
	localparam opcodeT OpcImm = 7'b0010011;
	localparam opcodeT OpcLoad = 7'b0000011;
	localparam opcodeT OpcStore = 7'b0100011;
	localparam opcodeT OpcBranch = 7'b1100011; // beq only
	localparam opcodeT OpcBranch2 = 7'b1100111; // bne, bge, blt
	localparam opcodeT OpcLui = 7'b0110111;
	localparam opcodeT OpcJal = 7'b1101111;

	typedef enum logic [1:0] {
		ShiftLeft = 2'd0,
		ShiftRightLogic = 2'd1,
		ShiftRightArith = 2'd2
	} shiftT;

	typedef enum logic [3:0] {
		OpNone, OpRegAlu, OpSlt, OpImmAlu, OpSlti, OpShift,
		OpLoad, OpStore, OpBranch, OpLui, OpJal
	} opClassT;

	typedef enum logic [1:0] {BrEq, BrNe, BrGe, BrLt} branchKindT;

	typedef enum logic [3:0] {
		Idle, Fetch, Decode,
		AluExec, SltExec, WriteBack, ShiftWrite,
		MemAddr, MemRead, LoadWrite, MemWrite,
		BranchCmp, LuiWrite, JalLink, JalJump
	} ctrlStateT;

endpackage

`default_nettype wire

//--- hdl/decodedIf.sv
`timescale 1ns/1ps
`default_nettype none

interface decodedIf;
	import ctrlPkg::*;

	opClassT opClass;
	aluOpT aluOp;
	memTypeT memType;
	shiftT shiftKind;
	branchKindT branchKind;

	modport producer (
		output opClass, aluOp, memType, shiftKind, branchKind
	);

	modport consumer (
		input opClass, aluOp, memType, shiftKind, branchKind
	);

endinterface

`default_nettype wire

//--- hdl/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
	input ctrlPkg::instrT instr,
	decodedIf.producer dec
);
	import ctrlPkg::*;

	opcodeT opcode;
	funct3T funct3;
	logic [6:0] funct7;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	always_comb begin
		dec.opClass = OpNone;
		dec.aluOp = AluSum;
		dec.memType = MemNone;
		dec.shiftKind = ShiftLeft;
		dec.branchKind = BrEq;

		case (opcode)
			OpcR: begin
				if (funct7 == 7'b0000000) begin
					case (funct3)
						3'b000: dec.opClass = OpRegAlu; // add
						3'b111: begin
							dec.opClass = OpRegAlu;
							dec.aluOp = AluAnd;
						end
						3'b010: begin
							dec.opClass = OpSlt;
							dec.aluOp = AluLoad;
						end
						default: dec.opClass = OpNone;
					endcase
				end else if (funct7 == 7'b0100000) begin // sub
					dec.opClass = OpRegAlu;
					dec.aluOp = AluSub;
				end
			end
			OpcImm: begin
				case (funct3)
					3'b000: dec.opClass = OpImmAlu; // addi
					3'b010: begin
						dec.opClass = OpSlti;
						dec.aluOp = AluLoad;
					end
					3'b001: dec.opClass = OpShift; // slli
					3'b101: begin
						// srli and srai differ only in bit 30
						if (instr[31:26] == 6'b000000) begin
							dec.opClass = OpShift;
							dec.shiftKind = ShiftRightLogic;
						end else if (instr[31:26] == 6'b010000) begin
							dec.opClass = OpShift;
							dec.shiftKind = ShiftRightArith;
						end
					end
					default: dec.opClass = OpNone;
				endcase
			end
			OpcLoad: begin
				dec.opClass = OpLoad;
				case (funct3)
					3'b000: dec.memType = LdByte;
					3'b001: dec.memType = LdHalf;
					3'b010: dec.memType = LdWord;
					3'b011: dec.memType = LdDouble;
					3'b100: dec.memType = LdByteU;
					3'b101: dec.memType = LdHalfU;
					3'b110: dec.memType = LdWordU;
					default: dec.opClass = OpNone;
				endcase
			end
			OpcStore: begin
				dec.opClass = OpStore;
				case (funct3)
					3'b111: dec.memType = StDouble; // sd keeps the legacy encoding
					3'b010: dec.memType = StWord;
					3'b001: dec.memType = StHalf;
					3'b000: dec.memType = StByte;
					default: dec.opClass = OpNone;
				endcase
			end
			OpcBranch: begin
				dec.opClass = OpBranch;
				dec.aluOp = AluSub;
			end
			OpcBranch2: begin
				dec.opClass = OpBranch;
				dec.aluOp = AluSub;
				case (funct3)
					3'b001: dec.branchKind = BrNe;
					3'b101: dec.branchKind = BrGe;
					3'b100: begin
						dec.branchKind = BrLt;
						dec.aluOp = AluCompare;
					end
					default: dec.opClass = OpNone; // Former jalr slot
				endcase
			end
			OpcLui: dec.opClass = OpLui;
			OpcJal: dec.opClass = OpJal;
			default: dec.opClass = OpNone;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/controlSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
	input logic rst, // Clock
	input logic clk, // Async reset, active high
	decodedIf.consumer dec,
	output ctrlPkg::ctrlStateT state
);
	import ctrlPkg::*;

	ctrlStateT nextState;

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			state <= Idle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = Idle;
		case (state)
			Idle: nextState = Fetch;
			Fetch: nextState = Decode;
			Decode: begin
				// Only branch point of the FSM
				case (dec.opClass)
					OpRegAlu, OpImmAlu: nextState = AluExec;
					OpSlt, OpSlti: nextState = SltExec;
					OpShift: nextState = ShiftWrite;
					OpLoad, OpStore: nextState = MemAddr;
					OpBranch: nextState = BranchCmp;
					OpLui: nextState = LuiWrite;
					OpJal: nextState = JalLink;
					default: nextState = Idle; // Unknown opcode
				endcase
			end
			AluExec: nextState = WriteBack;
			SltExec: nextState = WriteBack;
			WriteBack: nextState = Idle;
			ShiftWrite: nextState = Idle;
			MemAddr: begin
				if (dec.opClass == OpLoad) begin
					nextState = MemRead;
				end else begin
					nextState = MemWrite;
				end
			end
			MemRead: nextState = LoadWrite;
			LoadWrite: nextState = Idle;
			MemWrite: nextState = Idle;
			BranchCmp: nextState = Idle;
			LuiWrite: nextState = Idle;
			JalLink: nextState = JalJump;
			JalJump: nextState = Idle;
			default: nextState = Idle;
		endcase
	end

	// Every instruction starts with a fetch
	idleToFetch: assert property (
		@(posedge rst) disable iff (clk)
		state == Idle |=> state == Fetch
	);

	// Decode lasts exactly one cycle
	decodeOnce: assert property (
		@(posedge rst) disable iff (clk)
		state == Decode |=> state != Decode
	);

endmodule

`default_nettype wire

//--- hdl/controlWordGen.sv
`timescale 1ns/1ps
`default_nettype none

module controlWordGen (
	input ctrlPkg::ctrlStateT state,
	decodedIf.consumer dec,
	input logic aluZero,
	input logic aluLess,
	output logic pcWrite,
	output logic pcWriteCond,
	output logic irWrite,
	output logic regWrite,
	output logic memRead,
	output logic memDataWrite,
	output logic loadRegA,
	output logic loadRegB,
	output logic loadRegAluOut,
	output logic loadRegMemData,
	output logic selMuxPc,
	output ctrlPkg::muxSelT selMuxA,
	output ctrlPkg::muxSelT selMuxB,
	output logic selMuxAlu,
	output ctrlPkg::muxSelT selMuxMem,
	output ctrlPkg::aluOpT aluOperation,
	output ctrlPkg::shiftT shift,
	output ctrlPkg::memTypeT loadType,
	output ctrlPkg::memTypeT storeType
);
	import ctrlPkg::*;

	logic taken;
	logic useImm;
	logic isSlt;
	logic isLoad;

	assign useImm = (dec.opClass == OpImmAlu) || (dec.opClass == OpSlti);
	assign isSlt = (dec.opClass == OpSlt) || (dec.opClass == OpSlti);
	assign isLoad = dec.opClass == OpLoad;

	always_comb begin
		case (dec.branchKind)
			BrEq: taken = aluZero;
			BrNe: taken = !aluZero;
			BrGe: taken = !aluLess;
			default: taken = aluLess; // blt
		endcase
	end

	always_comb begin
		pcWrite = 1'b0;
		pcWriteCond = 1'b0;
		irWrite = 1'b0;
		regWrite = 1'b0;
		memRead = 1'b0;
		memDataWrite = 1'b0;
		loadRegA = 1'b0;
		loadRegB = 1'b0;
		loadRegAluOut = 1'b0;
		loadRegMemData = 1'b0;
		selMuxPc = 1'b0;
		selMuxA = 3'd0; // PC
		selMuxB = SelBRegB;
		selMuxAlu = 1'b0;
		selMuxMem = SelMemAluOut;
		aluOperation = AluLoad;
		shift = ShiftLeft;
		loadType = MemNone;
		storeType = MemNone;

		case (state)
			Fetch: begin
				selMuxB = SelBFour; // PC + 4
				selMuxMem = SelMemData;
				pcWrite = 1'b1;
				memRead = 1'b1;
				irWrite = 1'b1;
				aluOperation = AluSum;
			end
			Decode: begin
				selMuxB = SelBBranchOff; // Branch target precomputed
				memRead = 1'b1;
				loadRegA = 1'b1;
				loadRegB = 1'b1;
				loadRegAluOut = 1'b1;
				aluOperation = AluSum;
			end
			AluExec, SltExec, WriteBack: begin
				// Operand selects held through write back
				selMuxA = 3'd1;
				selMuxB = useImm ? SelBImm : SelBRegB;
				selMuxAlu = isSlt;
				aluOperation = dec.aluOp;
				loadRegAluOut = (state == AluExec);
				regWrite = (state == WriteBack);
			end
			ShiftWrite: begin
				shift = dec.shiftKind;
				selMuxMem = SelMemShift;
				regWrite = 1'b1;
			end
			MemAddr: begin
				selMuxA = 3'd1;
				selMuxB = SelBImm;
				selMuxMem = SelMemData;
				aluOperation = AluSum;
				loadRegAluOut = 1'b1;
				if (isLoad) begin
					loadType = dec.memType;
				end else begin
					storeType = dec.memType;
				end
			end
			MemRead: begin
				loadRegMemData = 1'b1;
				loadType = dec.memType;
			end
			LoadWrite: begin
				selMuxMem = SelMemData;
				regWrite = 1'b1;
				loadType = dec.memType; // Extension still needs the width
			end
			MemWrite: begin
				memDataWrite = 1'b1;
				storeType = dec.memType;
			end
			BranchCmp: begin
				selMuxA = 3'd1;
				selMuxMem = SelMemData;
				aluOperation = dec.aluOp;
				pcWrite = taken;
				pcWriteCond = taken;
				selMuxPc = taken; // Target from ALU-out
			end
			LuiWrite: begin
				selMuxB = SelBImm;
				selMuxMem = SelMemImm;
				regWrite = 1'b1;
			end
			JalLink: begin
				selMuxPc = 1'b1;
				selMuxB = SelBFour;
				pcWrite = 1'b1;
				regWrite = 1'b1;
				loadRegAluOut = 1'b1;
				aluOperation = AluSum;
			end
			JalJump: begin
				selMuxB = SelBBranchOff;
				pcWrite = 1'b1;
				loadRegAluOut = 1'b1;
				aluOperation = AluSum;
			end
			default: begin
			end
		endcase
	end

	// Register file and data memory never written in the same state
	always_comb begin
		assert (!(regWrite && memDataWrite));
		assert (!pcWriteCond || pcWrite);
	end

endmodule

`default_nettype wire

//--- hdl/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input logic rst, // Clock
	input logic clk, // Async reset, active high
	input ctrlPkg::instrT instr,
	input logic aluZero,
	input logic aluLess,
	output logic pcWrite,
	output logic pcWriteCond,
	output logic irWrite,
	output logic regWrite,
	output logic memRead,
	output logic memDataWrite,
	output logic loadRegA,
	output logic loadRegB,
	output logic loadRegAluOut,
	output logic loadRegMemData,
	output logic selMuxPc,
	output ctrlPkg::muxSelT selMuxA,
	output ctrlPkg::muxSelT selMuxB,
	output logic selMuxAlu,
	output ctrlPkg::muxSelT selMuxMem,
	output ctrlPkg::aluOpT aluOperation,
	output ctrlPkg::shiftT shift,
	output ctrlPkg::memTypeT loadType,
	output ctrlPkg::memTypeT storeType
);
	import ctrlPkg::*;

	ctrlStateT state;

	decodedIf dec ();

	instrDecoder instrDecoder_i (
		.instr(instr),
		.dec(dec.producer)
	);

	controlSequencer controlSequencer_i (
		.rst(rst),
		.clk(clk),
		.dec(dec.consumer),
		.state(state)
	);

	controlWordGen controlWordGen_i (
		.state(state),
		.dec(dec.consumer),
		.aluZero(aluZero),
		.aluLess(aluLess),
		.pcWrite(pcWrite),
		.pcWriteCond(pcWriteCond),
		.irWrite(irWrite),
		.regWrite(regWrite),
		.memRead(memRead),
		.memDataWrite(memDataWrite),
		.loadRegA(loadRegA),
		.loadRegB(loadRegB),
		.loadRegAluOut(loadRegAluOut),
		.loadRegMemData(loadRegMemData),
		.selMuxPc(selMuxPc),
		.selMuxA(selMuxA),
		.selMuxB(selMuxB),
		.selMuxAlu(selMuxAlu),
		.selMuxMem(selMuxMem),
		.aluOperation(aluOperation),
		.shift(shift),
		.loadType(loadType),
		.storeType(storeType)
	);

endmodule

`default_nettype wire

//--- tests/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic rst, // Clock, 40 ns period
	output logic clk // Reset, active high
);

	initial begin
		rst = 1'b0;
		forever begin
			#20 rst = ~rst;
		end
	end

	// Held for 10 cycles, released just after an edge
	initial begin
		clk = 1'b1;
		repeat (10) @(posedge rst);
		#2;
		clk = 1'b0;
	end

endmodule

`default_nettype wire

//--- tests/controlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;
	import ctrlPkg::*;

	// Masks have bit 0 for the first state after Decode
	typedef struct packed {
		logic [31:0] word;
		logic zero;
		logic less;
		logic [1:0] states;
		logic [2:0] aluOp;
		logic [2:0] ldType;
		logic [2:0] stType;
		logic [1:0] shiftKind;
		logic [2:0] regMask;
		logic [2:0] memMask;
		logic [2:0] pcMask;
		logic [2:0] condMask;
	} rowT;

	logic rst; // Clock
	logic clk; // Reset
	instrT instr;
	logic aluZero;
	logic aluLess;
	logic pcWrite;
	logic pcWriteCond;
	logic irWrite;
	logic regWrite;
	logic memRead;
	logic memDataWrite;
	logic loadRegA;
	logic loadRegB;
	logic loadRegAluOut;
	logic loadRegMemData;
	logic selMuxPc;
	muxSelT selMuxA;
	muxSelT selMuxB;
	logic selMuxAlu;
	muxSelT selMuxMem;
	aluOpT aluOperation;
	shiftT shift;
	memTypeT loadType;
	memTypeT storeType;
	logic [31:0] allOutputs;

	rowT rows[$];
	string rowNames[$];

	assign allOutputs = {pcWrite, pcWriteCond, irWrite, regWrite, memRead, memDataWrite,
		loadRegA, loadRegB, loadRegAluOut, loadRegMemData, selMuxPc, selMuxA, selMuxB,
		selMuxAlu, selMuxMem, aluOperation, shift, loadType, storeType};

	clockGen clockGen_i (.rst(rst), .clk(clk));

	controlUnit controlUnit_i (.*);

	task automatic stopRun();
		$display("Some tests failed");
		$fatal(1, "Stopped at the first failure");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
			stopRun();
		end
	endtask

	function automatic logic [31:0] encode(input logic [6:0] f7, input logic [2:0] f3,
		input logic [6:0] opc);
		return {f7, 5'd3, 5'd2, f3, 5'd1, opc}; // rs2 x3, rs1 x2, rd x1
	endfunction

	function automatic logic branchTaken(input branchKindT kind, input logic z, input logic l);
		case (kind)
			BrEq: return z;
			BrNe: return !z;
			BrGe: return !l;
			default: return l;
		endcase
	endfunction

	function automatic rowT makeRow(input logic [31:0] word, input logic [1:0] states,
		input logic [2:0] aluOp, input logic [2:0] ldType, input logic [2:0] stType,
		input logic [1:0] shiftKind, input logic [2:0] regMask, input logic [2:0] memMask,
		input logic [2:0] pcMask);
		rowT row;
		row.word = word;
		row.zero = 1'b0;
		row.less = 1'b0;
		row.states = states;
		row.aluOp = aluOp;
		row.ldType = ldType;
		row.stType = stType;
		row.shiftKind = shiftKind;
		row.regMask = regMask;
		row.memMask = memMask;
		row.pcMask = pcMask;
		row.condMask = 3'b000;
		return row;
	endfunction

	task automatic pushRow(input string name, input rowT row);
		rows.push_back(row);
		rowNames.push_back(name);
	endtask

	task automatic addAlu(input string name, input logic [31:0] word, input logic [2:0] aluOp);
		pushRow(name, makeRow(word, 2'd2, aluOp, MemNone, MemNone, ShiftLeft,
			3'b010, 3'b000, 3'b000));
	endtask

	task automatic addShift(input string name, input logic [6:0] f7, input logic [2:0] f3,
		input logic [1:0] kind);
		pushRow(name, makeRow(encode(f7, f3, OpcImm), 2'd1, AluLoad, MemNone, MemNone, kind,
			3'b001, 3'b000, 3'b000));
	endtask

	task automatic addLoad(input string name, input logic [2:0] f3, input logic [2:0] width);
		pushRow(name, makeRow(encode(7'h00, f3, OpcLoad), 2'd3, AluSum, width, MemNone,
			ShiftLeft, 3'b100, 3'b000, 3'b000));
	endtask

	task automatic addStore(input string name, input logic [2:0] f3, input logic [2:0] width);
		pushRow(name, makeRow(encode(7'h00, f3, OpcStore), 2'd2, AluSum, MemNone, width,
			ShiftLeft, 3'b000, 3'b010, 3'b000));
	endtask

	// Every flag combination, taken decided by the branch rule
	task automatic addBranch(input string name, input logic [31:0] word, input logic [2:0] aluOp,
		input branchKindT kind);
		rowT row;
		logic taken;
		for (int f = 0; f < 4; f++) begin
			row = makeRow(word, 2'd1, aluOp, MemNone, MemNone, ShiftLeft, 3'b000, 3'b000, 3'b000);
			row.zero = f[1];
			row.less = f[0];
			taken = branchTaken(kind, row.zero, row.less);
			row.pcMask = {2'b00, taken};
			row.condMask = {2'b00, taken};
			pushRow($sformatf("%s z=%0b l=%0b", name, row.zero, row.less), row);
		end
	endtask

	task automatic buildTable();
		addAlu("add", encode(7'h00, 3'b000, OpcR), AluSum);
		addAlu("sub", encode(7'h20, 3'b000, OpcR), AluSub);
		addAlu("and", encode(7'h00, 3'b111, OpcR), AluAnd);
		addAlu("addi", encode(7'h05, 3'b000, OpcImm), AluSum);
		addAlu("slt", encode(7'h00, 3'b010, OpcR), AluLoad);
		addAlu("slti", encode(7'h7f, 3'b010, OpcImm), AluLoad);
		addShift("slli", 7'h00, 3'b001, ShiftLeft);
		addShift("srli", 7'h00, 3'b101, ShiftRightLogic);
		addShift("srai", 7'h20, 3'b101, ShiftRightArith);
		addLoad("lb", 3'b000, LdByte);
		addLoad("lh", 3'b001, LdHalf);
		addLoad("lw", 3'b010, LdWord);
		addLoad("ld", 3'b011, LdDouble);
		addLoad("lbu", 3'b100, LdByteU);
		addLoad("lhu", 3'b101, LdHalfU);
		addLoad("lwu", 3'b110, LdWordU);
		addStore("sb", 3'b000, StByte);
		addStore("sh", 3'b001, StHalf);
		addStore("sw", 3'b010, StWord);
		addStore("sd", 3'b111, StDouble); // Legacy funct3
		addBranch("beq", encode(7'h00, 3'b000, OpcBranch), AluSub, BrEq);
		addBranch("bne", encode(7'h00, 3'b001, OpcBranch2), AluSub, BrNe);
		addBranch("bge", encode(7'h00, 3'b101, OpcBranch2), AluSub, BrGe);
		addBranch("blt", encode(7'h00, 3'b100, OpcBranch2), AluCompare, BrLt);
		pushRow("lui", makeRow(encode(7'h12, 3'b101, OpcLui), 2'd1, AluLoad, MemNone, MemNone,
			ShiftLeft, 3'b001, 3'b000, 3'b000));
		pushRow("jal", makeRow(encode(7'h00, 3'b000, OpcJal), 2'd2, AluSum, MemNone, MemNone,
			ShiftLeft, 3'b001, 3'b000, 3'b011));
		pushRow("unknown", makeRow(encode(7'h00, 3'b000, 7'h7f), 2'd0, AluLoad, MemNone,
			MemNone, ShiftLeft, 3'b000, 3'b000, 3'b000));
		pushRow("old jalr", makeRow(encode(7'h00, 3'b000, OpcBranch2), 2'd0, AluLoad, MemNone,
			MemNone, ShiftLeft, 3'b000, 3'b000, 3'b000));
	endtask

	task automatic waitForFetch(input string name);
		int count;
		count = 0;
		@(negedge rst);
		while (irWrite !== 1'b1) begin
			count++;
			if (count > 4) begin
				$display("Timeout: no instruction fetch seen for %s", name);
				stopRun();
			end
			@(negedge rst);
		end
	endtask

	task automatic waitForIdle(input string name);
		int count;
		count = 0;
		@(negedge rst);
		while (allOutputs !== 32'd0) begin
			count++;
			if (count > 6) begin
				$display("Timeout: controller never went idle after %s", name);
				stopRun();
			end
			@(negedge rst);
		end
	endtask

	task automatic checkFetch(input string name);
		checkValue({name, " irWrite"}, 1, 32'(irWrite));
		checkValue({name, " memRead"}, 1, 32'(memRead));
		checkValue({name, " pcWrite"}, 1, 32'(pcWrite));
		checkValue({name, " aluOperation"}, 32'(AluSum), 32'(aluOperation));
		checkValue({name, " regWrite"}, 0, 32'(regWrite));
	endtask

	// Starts and ends on a falling edge in Idle
	task automatic runRow(input int idx);
		rowT row;
		string name;
		int cycles;
		logic [1:0] slot;
		logic [2:0] regSeen;
		logic [2:0] memSeen;
		logic [2:0] pcSeen;
		logic [2:0] condSeen;
		row = rows[idx];
		name = rowNames[idx];
		cycles = 0;
		regSeen = 3'b000;
		memSeen = 3'b000;
		pcSeen = 3'b000;
		condSeen = 3'b000;
		@(posedge rst); // Idle to Fetch
		#2;
		instr = row.word;
		aluZero = row.zero;
		aluLess = row.less;
		waitForFetch(name);
		checkFetch({name, " fetch"});
		@(negedge rst);
		checkValue({name, " irWrite in Decode"}, 0, 32'(irWrite));
		checkValue({name, " loadRegA in Decode"}, 1, 32'(loadRegA));
		@(negedge rst);
		while (allOutputs !== 32'd0) begin
			if (cycles >= 3) begin
				$display("Timeout: %s stayed busy more than 3 cycles after Decode", name);
				stopRun();
			end
			slot = cycles[1:0];
			if (cycles == 0) begin
				checkValue({name, " aluOperation"}, 32'(row.aluOp), 32'(aluOperation));
				checkValue({name, " loadType"}, 32'(row.ldType), 32'(loadType));
				checkValue({name, " storeType"}, 32'(row.stType), 32'(storeType));
				checkValue({name, " shift"}, 32'(row.shiftKind), 32'(shift));
			end
			regSeen[slot] = regWrite;
			memSeen[slot] = memDataWrite;
			pcSeen[slot] = pcWrite;
			condSeen[slot] = pcWriteCond;
			cycles++;
			@(negedge rst);
		end
		checkValue({name, " cycles after Decode"}, 32'(row.states), cycles);
		checkValue({name, " regWrite cycles"}, 32'(row.regMask), 32'(regSeen));
		checkValue({name, " memDataWrite cycles"}, 32'(row.memMask), 32'(memSeen));
		checkValue({name, " pcWrite cycles"}, 32'(row.pcMask), 32'(pcSeen));
		checkValue({name, " pcWriteCond cycles"}, 32'(row.condMask), 32'(condSeen));
	endtask

	initial begin
		int count;
		instr = 32'h0000_0000; // Opcode 0 decodes to nothing
		aluZero = 1'b0;
		aluLess = 1'b0;
		buildTable();
		count = 0;
		@(negedge rst);
		while (irWrite !== 1'b1) begin
			checkValue("outputs before first fetch", 0, allOutputs);
			count++;
			if (count > 20) begin
				$display("Timeout: no fetch after reset was released");
				stopRun();
			end
			@(negedge rst);
		end
		checkFetch("first fetch");
		waitForIdle("first fetch");
		for (int i = 0; i < rows.size(); i++) begin
			runRow(i);
		end
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
hdl/ctrlPkg.sv
hdl/decodedIf.sv
hdl/instrDecoder.sv
hdl/controlSequencer.sv
hdl/controlWordGen.sv
hdl/controlUnit.sv
tests/clockGen.sv
tests/controlUnitTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= controlUnitTb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG = All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
